// ==== icache_ctrl.sv ====
`timescale 1ns/1ps
// instruction cache controller
// pipelined cpu handshake, hit detection and word select,
// miss FSM and per-set age bits for two-way replacement

module icache_ctrl #(
    parameter int unsigned ADDR_W        = 16,
    parameter int unsigned NUM_SETS_LOG2 = 3
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    // cpu side
    input  logic                     cpu_cyc_i,
    input  logic                     cpu_stb_i,
    input  logic [ADDR_W-1:0]        cpu_addr_i,
    output logic                     cpu_stall_o,
    output logic                     cpu_ack_o,
    output icache_pkg::word_t        cpu_rdata_o,

    // line store
    output logic                     rd_en_o,
    output logic [NUM_SETS_LOG2-1:0] rd_index_o,
    output logic                     wr_en_o,
    output icache_pkg::way_t         wr_way_o,
    output logic [NUM_SETS_LOG2-1:0] wr_index_o,
    output logic [ADDR_W-NUM_SETS_LOG2-icache_pkg::OFFSET_W-1:0] wr_tag_o,
    output icache_pkg::line_t        wr_line_o,
    input  logic [icache_pkg::NUM_WAYS-1:0] rd_valid_i,
    input  logic [ADDR_W-NUM_SETS_LOG2-icache_pkg::OFFSET_W-1:0] rd_tag_i [icache_pkg::NUM_WAYS],
    input  icache_pkg::line_t        rd_line_i [icache_pkg::NUM_WAYS],

    // refill engine
    output logic                     refill_req_o,
    output logic [ADDR_W-icache_pkg::OFFSET_W-1:0] refill_addr_o,
    input  logic                     refill_done_i,
    input  icache_pkg::line_t        refill_line_i
);

    import icache_pkg::*;

    localparam int unsigned TAG_W    = ADDR_W - NUM_SETS_LOG2 - OFFSET_W;
    localparam int unsigned NUM_SETS = 2 ** NUM_SETS_LOG2;

    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [NUM_SETS_LOG2-1:0] index_t;
    typedef logic [OFFSET_W-1:0]      offset_t;

    typedef enum logic [1:0] {RUNNING, WAIT_MEMORY, REFILL} state_t;

    state_t              state_q, state_d;
    logic                accept;
    logic                req_q;       // request waiting for its hit/miss decision
    logic [ADDR_W-1:0]   addr_q;
    tag_t                tag_q;
    index_t              index_q;
    offset_t             offset_q;
    logic [NUM_WAYS-1:0] match;
    logic                hit;
    logic                miss;
    way_t                hit_way;
    way_t                victim_way;
    logic [NUM_SETS-1:0] age_q;       // points at the way to replace next

    function automatic word_t pick_word(line_t line, offset_t offset);
        pick_word = line[offset * WORD_W +: WORD_W];
    endfunction

    // ********************
    // request pipeline
    // ********************

    assign accept = cpu_cyc_i & cpu_stb_i & ~cpu_stall_o;

    // store is read at the accepting edge
    assign rd_en_o    = accept;
    assign rd_index_o = cpu_addr_i[OFFSET_W +: NUM_SETS_LOG2];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= cpu_addr_i;
        end
    end

    assign {tag_q, index_q, offset_q} = addr_q;

    // ********************
    // hit detection
    // ********************

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_match
        assign match[w] = rd_valid_i[w] && (rd_tag_i[w] == tag_q);
    end

    assign hit     = req_q & (|match);
    assign miss    = req_q & ~(|match);
    assign hit_way = match[1];              // a tag lives in one way at most

    // hit data in the decision cycle, refill data with early restart
    assign cpu_ack_o   = hit | (state_q == REFILL);
    assign cpu_rdata_o = (state_q == REFILL) ? pick_word(refill_line_i, offset_q)
                                             : pick_word(rd_line_i[hit_way], offset_q);

    // ********************
    // miss FSM
    // ********************

    always_comb begin
        state_d      = state_q;
        cpu_stall_o  = 1'b0;
        refill_req_o = 1'b0;
        wr_en_o      = 1'b0;
        case (state_q)
            RUNNING: begin
                if (miss) begin
                    cpu_stall_o  = 1'b1;
                    refill_req_o = 1'b1;
                    state_d      = WAIT_MEMORY;
                end
            end
            WAIT_MEMORY: begin
                cpu_stall_o = 1'b1;
                if (refill_done_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                cpu_stall_o = 1'b1;
                wr_en_o     = 1'b1;         // line goes into the victim way
                state_d     = RUNNING;
            end
            default: state_d = RUNNING;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= RUNNING;
        end else begin
            state_q <= state_d;
        end
    end

    assign refill_addr_o = addr_q[ADDR_W-1:OFFSET_W];
    assign victim_way    = age_q[index_q];
    assign wr_way_o      = victim_way;
    assign wr_index_o    = index_q;
    assign wr_tag_o      = tag_q;
    assign wr_line_o     = refill_line_i;

    // after a fill the set points at the other way
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            age_q <= '0;
        end else if (state_q == REFILL) begin
            age_q[index_q] <= ~victim_way;
        end
    end

endmodule

// ==== icache_line_store.sv ====
`timescale 1ns/1ps
// line store for the two-way instruction cache
// holds valid bits, tags and line data for every set and way,
// reads a whole set into registers and writes one way of one set

module icache_line_store #(
    parameter int unsigned ADDR_W        = 16,
    parameter int unsigned NUM_SETS_LOG2 = 3
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    // read port, whole set
    input  logic                     rd_en_i,
    input  logic [NUM_SETS_LOG2-1:0] rd_index_i,

    // write port, one way
    input  logic                     wr_en_i,
    input  icache_pkg::way_t         wr_way_i,
    input  logic [NUM_SETS_LOG2-1:0] wr_index_i,
    input  logic [ADDR_W-NUM_SETS_LOG2-icache_pkg::OFFSET_W-1:0] wr_tag_i,
    input  icache_pkg::line_t        wr_line_i,

    // registered set contents
    output logic [icache_pkg::NUM_WAYS-1:0] rd_valid_o,
    output logic [ADDR_W-NUM_SETS_LOG2-icache_pkg::OFFSET_W-1:0] rd_tag_o [icache_pkg::NUM_WAYS],
    output icache_pkg::line_t        rd_line_o [icache_pkg::NUM_WAYS]
);

    import icache_pkg::*;

    localparam int unsigned TAG_W    = ADDR_W - NUM_SETS_LOG2 - OFFSET_W;
    localparam int unsigned NUM_SETS = 2 ** NUM_SETS_LOG2;

    typedef logic [TAG_W-1:0] tag_t;

    logic [NUM_WAYS-1:0] valid_q  [NUM_SETS];            // one bit per way
    tag_t                tag_mem  [NUM_SETS][NUM_WAYS];
    line_t               data_mem [NUM_SETS][NUM_WAYS];

    // ********************
    // valid bits
    // ********************

    // lines only ever become valid, there is no invalidate
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q    <= '{default: '0};
            rd_valid_o <= '0;
        end else begin
            if (rd_en_i) begin
                rd_valid_o <= valid_q[rd_index_i];
            end
            if (wr_en_i) begin
                valid_q[wr_index_i][wr_way_i] <= 1'b1;
            end
        end
    end

    // ********************
    // tag store
    // ********************

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tag_o[w] <= tag_mem[rd_index_i][w];
            end
        end
        if (wr_en_i) begin
            tag_mem[wr_index_i][wr_way_i] <= wr_tag_i;
        end
    end

    // ********************
    // data store
    // ********************

    // a read in the same cycle as a write sees the old line
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_line_o[w] <= data_mem[rd_index_i][w];
            end
        end
        if (wr_en_i) begin
            data_mem[wr_index_i][wr_way_i] <= wr_line_i;  // whole line at once
        end
    end

endmodule

// ==== icache_pkg.sv ====
// shared widths and vector types for the instruction cache
// a line holds four 32-bit words, two ways per set

package icache_pkg;

    // ********************
    // word and line geometry
    // ********************

    localparam int unsigned WORD_W         = 32;  // one instruction word
    localparam int unsigned OFFSET_W       = 2;   // word select inside a line
    localparam int unsigned WORDS_PER_LINE = 2 ** OFFSET_W;

    // a full line comes back from memory in one beat
    localparam int unsigned LINE_W = WORDS_PER_LINE * WORD_W;

    // ********************
    // associativity
    // ********************

    // the age bit replacement only covers two ways
    localparam int unsigned NUM_WAYS = 2;

    // ********************
    // vector types
    // ********************

    typedef logic [WORD_W-1:0] word_t;   // cpu read data
    typedef logic [LINE_W-1:0] line_t;   // memory read data and store contents

    // way index, one bit for two ways
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

endpackage

// ==== icache_refill.sv ====
`timescale 1ns/1ps
// refill engine, memory-side bus master
// requests one line per miss, holds the strobe while memory stalls,
// captures the returned line and holds it for the controller

module icache_refill #(
    parameter int unsigned ADDR_W = 16
) (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,

    // controller side
    input  logic                                 refill_req_i,
    input  logic [ADDR_W-icache_pkg::OFFSET_W-1:0] refill_addr_i,
    output logic                                 refill_done_o,
    output icache_pkg::line_t                    refill_line_o,

    // memory bus
    output logic                                 mem_cyc_o,
    output logic                                 mem_stb_o,
    output logic [ADDR_W-icache_pkg::OFFSET_W-1:0] mem_addr_o,
    input  logic                                 mem_stall_i,
    input  logic                                 mem_ack_i,
    input  icache_pkg::line_t                    mem_rdata_i
);

    import icache_pkg::*;

    typedef logic [ADDR_W-OFFSET_W-1:0] line_addr_t;
    typedef enum logic [1:0] {IDLE, REQUEST, WAIT_ACK} state_t;

    state_t     state_q, state_d;
    line_addr_t addr_q;          // line address held while stalled

    always_comb begin
        state_d    = state_q;
        mem_cyc_o  = 1'b0;
        mem_stb_o  = 1'b0;
        mem_addr_o = addr_q;
        case (state_q)
            IDLE: begin
                if (refill_req_i) begin  // strobe right away
                    mem_cyc_o  = 1'b1;
                    mem_stb_o  = 1'b1;
                    mem_addr_o = refill_addr_i;
                    state_d    = mem_stall_i ? REQUEST : WAIT_ACK;
                end
            end
            REQUEST: begin
                mem_cyc_o = 1'b1;
                mem_stb_o = 1'b1;        // keep strobing until stall drops
                if (!mem_stall_i) begin
                    state_d = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                mem_cyc_o = 1'b1;
                if (mem_ack_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q       <= IDLE;
            refill_done_o <= 1'b0;
        end else begin
            state_q       <= state_d;
            refill_done_o <= (state_q == WAIT_ACK) && mem_ack_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && refill_req_i) begin
            addr_q <= refill_addr_i;
        end
        if (state_q == WAIT_ACK && mem_ack_i) begin
            refill_line_o <= mem_rdata_i;  // ack cycle carries the line
        end
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps
// two-way set associative instruction cache subsystem
// ties the controller, line store and refill engine together

module icache_top #(
    parameter int unsigned ADDR_W        = 16,
    parameter int unsigned NUM_SETS_LOG2 = 3
) (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,

    // cpu bus, slave side
    input  logic                                   cpu_cyc_i,
    input  logic                                   cpu_stb_i,
    input  logic [ADDR_W-1:0]                      cpu_addr_i,
    output logic                                   cpu_stall_o,
    output logic                                   cpu_ack_o,
    output icache_pkg::word_t                      cpu_rdata_o,

    // memory bus, master side
    output logic                                   mem_cyc_o,
    output logic                                   mem_stb_o,
    output logic [ADDR_W-icache_pkg::OFFSET_W-1:0] mem_addr_o,
    input  logic                                   mem_stall_i,
    input  logic                                   mem_ack_i,
    input  icache_pkg::line_t                      mem_rdata_i
);

    import icache_pkg::*;

    localparam int unsigned TAG_W = ADDR_W - NUM_SETS_LOG2 - OFFSET_W;

    // ********************
    // store and refill wiring
    // ********************

    logic                       rd_en;
    logic [NUM_SETS_LOG2-1:0]   rd_index;
    logic                       wr_en;
    way_t                       wr_way;
    logic [NUM_SETS_LOG2-1:0]   wr_index;
    logic [TAG_W-1:0]           wr_tag;
    line_t                      wr_line;
    logic [NUM_WAYS-1:0]        rd_valid;
    logic [TAG_W-1:0]           rd_tag [NUM_WAYS];
    line_t                      rd_line [NUM_WAYS];
    logic                       refill_req;
    logic [ADDR_W-OFFSET_W-1:0] refill_addr;
    logic                       refill_done;
    line_t                      refill_line;

    icache_ctrl #(
        .ADDR_W        (ADDR_W),
        .NUM_SETS_LOG2 (NUM_SETS_LOG2)
    ) u_ctrl (
        .clk_i, .rstn_i,
        .cpu_cyc_i, .cpu_stb_i, .cpu_addr_i,
        .cpu_stall_o, .cpu_ack_o, .cpu_rdata_o,
        .rd_en_o       (rd_en),
        .rd_index_o    (rd_index),
        .wr_en_o       (wr_en),
        .wr_way_o      (wr_way),
        .wr_index_o    (wr_index),
        .wr_tag_o      (wr_tag),
        .wr_line_o     (wr_line),
        .rd_valid_i    (rd_valid),
        .rd_tag_i      (rd_tag),
        .rd_line_i     (rd_line),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .refill_done_i (refill_done),
        .refill_line_i (refill_line)
    );

    icache_line_store #(
        .ADDR_W        (ADDR_W),
        .NUM_SETS_LOG2 (NUM_SETS_LOG2)
    ) u_line_store (
        .clk_i, .rstn_i,
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .wr_en_i    (wr_en),
        .wr_way_i   (wr_way),
        .wr_index_i (wr_index),
        .wr_tag_i   (wr_tag),
        .wr_line_i  (wr_line),
        .rd_valid_o (rd_valid),
        .rd_tag_o   (rd_tag),
        .rd_line_o  (rd_line)
    );

    icache_refill #(
        .ADDR_W (ADDR_W)
    ) u_refill (
        .clk_i, .rstn_i,
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .refill_done_o (refill_done),
        .refill_line_o (refill_line),
        .mem_cyc_o, .mem_stb_o, .mem_addr_o,
        .mem_stall_i, .mem_ack_i, .mem_rdata_i
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_icache \
    -Mdir obj_dir -o tb_icache > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_icache > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "testbench reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

// ==== tb_icache.sv ====
`timescale 1ns/1ps
// testbench for the two-way instruction cache
// mirrors tags, valid and age bits and checks both buses with assertions

module tb_icache;

    import icache_pkg::*;

    localparam int unsigned ADDR_W        = 16;
    localparam int unsigned NUM_SETS_LOG2 = 3;
    localparam int unsigned TAG_W         = ADDR_W - NUM_SETS_LOG2 - OFFSET_W;
    localparam int unsigned NUM_SETS      = 2 ** NUM_SETS_LOG2;
    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 10;
    localparam int          NUM_RANDOM    = 200;
    localparam int          NUM_REQUESTS  = 13 + NUM_RANDOM;
    localparam int          WATCHDOG_NS   = (NUM_REQUESTS * 20 + RESET_CYCLES + 20) * CLK_PERIOD;
    localparam logic [31:0] FILL_KEY      = 32'h5A3C_96E1;

    logic clk, rstn;
    logic cpu_cyc, cpu_stb, cpu_stall, cpu_ack;
    logic [ADDR_W-1:0] cpu_addr;
    word_t cpu_rdata;
    logic mem_cyc, mem_stb, mem_stall, mem_ack;
    logic [ADDR_W-OFFSET_W-1:0] mem_addr;
    line_t mem_rdata;

    integer seed = 32'h2798_1279;

    // reference model of the tag state
    logic             model_valid [NUM_SETS][2];
    logic [TAG_W-1:0] model_tag   [NUM_SETS][2];
    logic             model_age   [NUM_SETS];

    // queue of accepted addresses waiting for their ack
    logic [ADDR_W-1:0] pend_addr [4];
    logic [1:0]        pend_head, pend_tail;
    int                pend_count;

    logic                       accepted, hit_due, miss_open, seen_request, held_stb;
    logic [ADDR_W-OFFSET_W-1:0] miss_line, held_addr;
    int                         issue_cnt;

    icache_top #(.ADDR_W(ADDR_W), .NUM_SETS_LOG2(NUM_SETS_LOG2)) DUT (
        .clk_i(clk), .rstn_i(rstn),
        .cpu_cyc_i(cpu_cyc), .cpu_stb_i(cpu_stb), .cpu_addr_i(cpu_addr),
        .cpu_stall_o(cpu_stall), .cpu_ack_o(cpu_ack), .cpu_rdata_o(cpu_rdata),
        .mem_cyc_o(mem_cyc), .mem_stb_o(mem_stb), .mem_addr_o(mem_addr),
        .mem_stall_i(mem_stall), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
    );

    tb_icache_mem #(.ADDR_W(ADDR_W), .FILL_KEY(FILL_KEY)) u_mem (
        .clk_i(clk), .rstn_i(rstn),
        .mem_cyc_i(mem_cyc), .mem_stb_i(mem_stb), .mem_addr_i(mem_addr),
        .mem_stall_o(mem_stall), .mem_ack_o(mem_ack), .mem_rdata_o(mem_rdata)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("Mismatch at %0t: %s", $time, what));
    endtask

    function automatic word_t expected_word(input logic [ADDR_W-1:0] addr);
        logic [31:0] line_num, word_num;
        line_num = 32'(addr[ADDR_W-1:OFFSET_W]);
        word_num = 32'(addr[OFFSET_W-1:0]);
        return ((line_num << 2) + word_num) ^ FILL_KEY;
    endfunction

    function automatic logic predict_hit(input logic [ADDR_W-1:0] addr);
        logic [NUM_SETS_LOG2-1:0] idx;
        logic [TAG_W-1:0]         tag;
        idx = addr[OFFSET_W +: NUM_SETS_LOG2];
        tag = addr[ADDR_W-1 -: TAG_W];
        return (model_valid[idx][0] && model_tag[idx][0] == tag) ||
               (model_valid[idx][1] && model_tag[idx][1] == tag);
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int unsigned tag,
                                                    input int unsigned index,
                                                    input int unsigned offset);
        logic [31:0] t, s, o;
        t = tag;
        s = index;
        o = offset;
        return {t[TAG_W-1:0], s[NUM_SETS_LOG2-1:0], o[OFFSET_W-1:0]};
    endfunction

    // ********************
    // monitor and model
    // ********************

    assign accepted = cpu_cyc & cpu_stb & ~cpu_stall;

    always @(posedge clk) begin : monitor
        logic [NUM_SETS_LOG2-1:0] idx;
        logic                     victim;
        if (!rstn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                model_valid[s][0] <= 1'b0;
                model_valid[s][1] <= 1'b0;
                model_age[s]      <= 1'b0;
            end
            pend_head    <= '0;
            pend_tail    <= '0;
            pend_count   <= 0;
            {hit_due, miss_open, seen_request, held_stb} <= '0;
            issue_cnt    <= 0;
        end else begin
            held_stb   <= mem_stb & mem_stall;
            held_addr  <= mem_addr;
            hit_due    <= 1'b0;
            pend_count <= pend_count + (accepted ? 1 : 0) - (cpu_ack ? 1 : 0);
            if (mem_stb && !mem_stall) issue_cnt <= issue_cnt + 1;
            if (cpu_ack) pend_head <= pend_head + 2'd1;
            if (cpu_ack && miss_open) miss_open <= 1'b0;  // the miss's own ack
            if (accepted) begin
                seen_request         <= 1'b1;
                pend_addr[pend_tail] <= cpu_addr;
                pend_tail            <= pend_tail + 2'd1;
                if (predict_hit(cpu_addr)) begin
                    hit_due <= 1'b1;
                end else begin
                    idx    = cpu_addr[OFFSET_W +: NUM_SETS_LOG2];
                    victim = model_age[idx];
                    model_valid[idx][victim] <= 1'b1;
                    model_tag[idx][victim]   <= cpu_addr[ADDR_W-1 -: TAG_W];
                    model_age[idx]           <= ~victim;
                    miss_open  <= 1'b1;
                    issue_cnt  <= 0;
                    miss_line  <= cpu_addr[ADDR_W-1:OFFSET_W];
                end
            end
        end
    end

    // ********************
    // assertions
    // ********************

    a_idle: assert property (@(posedge clk) disable iff (!rstn)
        !seen_request |-> !(cpu_stall || cpu_ack || mem_cyc || mem_stb))
        else abort_run("bus active after reset before the first request");
    a_ack_count: assert property (@(posedge clk) disable iff (!rstn)
        cpu_ack |-> pend_count != 0)
        else abort_run("ack arrived with no request outstanding");
    a_rdata: assert property (@(posedge clk) disable iff (!rstn)
        cpu_ack |-> cpu_rdata == expected_word(pend_addr[pend_head]))
        else report_mismatch("read data differs from the memory fill rule");
    a_hit_ack: assert property (@(posedge clk) disable iff (!rstn)
        hit_due |-> cpu_ack)
        else abort_run("predicted hit not acked in the cycle after acceptance");
    a_stb_miss: assert property (@(posedge clk) disable iff (!rstn)
        mem_stb |-> miss_open && mem_cyc)
        else abort_run("memory strobe without a predicted miss");
    a_stall: assert property (@(posedge clk) disable iff (!rstn)
        cpu_stall == miss_open)
        else abort_run("stall does not match the span of the predicted miss");
    a_one_req: assert property (@(posedge clk) disable iff (!rstn)
        (mem_stb && !mem_stall) |-> issue_cnt == 0)
        else abort_run("second memory request issued for one miss");
    a_line_addr: assert property (@(posedge clk) disable iff (!rstn)
        (mem_stb && !mem_stall) |-> mem_addr == miss_line)
        else report_mismatch("memory address differs from the missed line");
    a_miss_done: assert property (@(posedge clk) disable iff (!rstn)
        (cpu_ack && miss_open) |-> issue_cnt == 1)
        else abort_run("miss acked without exactly one memory request");
    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        held_stb |-> mem_stb && mem_addr == held_addr)
        else abort_run("strobe or address changed while memory stalled");

    // ********************
    // stimulus
    // ********************

    task automatic fetch(input logic [ADDR_W-1:0] addr);
        logic taken;
        cpu_cyc  <= 1'b1;
        cpu_stb  <= 1'b1;
        cpu_addr <= addr;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !cpu_stall;  // stable until the next rising edge
            @(posedge clk);
        end
    endtask

    task automatic pause();
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drain();
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        @(negedge clk);
        while (pend_count != 0) @(negedge clk);
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all requests were acked");
    end

    initial begin
        int unsigned tag, index, offset;
        cpu_cyc  = 1'b0;
        cpu_stb  = 1'b0;
        cpu_addr = '0;
        rstn     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) @(posedge clk);        // quiet bus after reset
        for (int w = 0; w < 4; w++) fetch(make_addr(1, 2, w));
        drain();
        for (int w = 3; w >= 0; w--) fetch(make_addr(1, 2, w));  // back-to-back hits
        drain();
        // three tags fill set 5 before the survivor and the evicted tag return
        fetch(make_addr(4, 5, 0));
        fetch(make_addr(5, 5, 1));
        fetch(make_addr(6, 5, 2));
        fetch(make_addr(5, 5, 3));
        fetch(make_addr(4, 5, 2));
        drain();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            tag    = $unsigned($random(seed)) % 4;
            index  = $unsigned($random(seed)) % NUM_SETS;
            offset = $unsigned($random(seed)) % WORDS_PER_LINE;
            fetch(make_addr(tag, index, offset));
            if ($unsigned($random(seed)) % 8 == 0) pause();
        end
        drain();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== tb_icache_mem.sv ====
`timescale 1ns/1ps
// behavioral line memory for the cache testbench
// random stall, answers 1 to 6 cycles after a request is taken

module tb_icache_mem #(
    parameter int unsigned ADDR_W   = 16,
    parameter logic [31:0] FILL_KEY = 32'h0
) (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  logic                                   mem_cyc_i,
    input  logic                                   mem_stb_i,
    input  logic [ADDR_W-icache_pkg::OFFSET_W-1:0] mem_addr_i,
    output logic                                   mem_stall_o,
    output logic                                   mem_ack_o,
    output icache_pkg::line_t                      mem_rdata_o
);

    import icache_pkg::*;

    integer                     seed = 32'h2798_1279;
    logic [31:0]                rnd;
    logic                       busy;       // one request in service
    int unsigned                wait_cnt;
    logic [ADDR_W-OFFSET_W-1:0] line_q;

    // word w of line l holds (l*4 + w) xor the key
    function automatic line_t build_line(input logic [ADDR_W-OFFSET_W-1:0] line_addr);
        logic [31:0] base;
        line_t       line;
        base = 32'(line_addr) << 2;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w * WORD_W +: WORD_W] = (base + 32'(w)) ^ FILL_KEY;
        end
        return line;
    endfunction

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            mem_stall_o <= 1'b0;
            mem_ack_o   <= 1'b0;
            mem_rdata_o <= '0;
            busy        <= 1'b0;
            wait_cnt    <= 0;
        end else begin
            rnd = $random(seed);
            mem_stall_o <= (rnd[1:0] == 2'b00);  // about one cycle in four
            mem_ack_o   <= 1'b0;
            if (busy) begin
                if (wait_cnt == 1) begin
                    mem_ack_o   <= 1'b1;
                    mem_rdata_o <= build_line(line_q);
                    busy        <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_cyc_i && mem_stb_i && !mem_stall_o) begin
                busy     <= 1'b1;
                line_q   <= mem_addr_i;
                wait_cnt <= 1 + ($unsigned($random(seed)) % 6);
            end
        end
    end

endmodule

// ==== vlog.f ====
icache_pkg.sv
icache_line_store.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv
